// ==== logic/rvPkg.sv ====
package rvPkg;

    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;

    typedef logic [XLEN-1:0]              wordT;
    typedef logic [$clog2(REG_COUNT)-1:0] regAddrT;
    typedef logic [6:0]                   opcodeT;

    localparam wordT RESET_VECTOR = 32'h0000_0800;

    // RV32I major opcodes
    localparam opcodeT OP_REG    = 7'b0110011;
    localparam opcodeT OP_IMM    = 7'b0010011;
    localparam opcodeT OP_LUI    = 7'b0110111;
    localparam opcodeT OP_AUIPC  = 7'b0010111;
    localparam opcodeT OP_JAL    = 7'b1101111;
    localparam opcodeT OP_JALR   = 7'b1100111;
    localparam opcodeT OP_BRANCH = 7'b1100011;
    localparam opcodeT OP_LOAD   = 7'b0000011;
    localparam opcodeT OP_STORE  = 7'b0100011;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } aluOpT;

    // Values follow funct3 of the branch encoding
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branchOpT;

    typedef enum logic [1:0] {
        PC_SEQUENTIAL,
        PC_RELATIVE,   // pc + imm
        PC_ABSOLUTE,   // aluResult
        PC_BRANCH      // Relative if taken
    } pcModeT;

    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_LINK,
        WB_LOAD
    } wbSelT;

    typedef enum logic [1:0] {
        OPA_RS1,
        OPA_PC,
        OPA_ZERO
    } opASelT;

    typedef enum logic [2:0] {
        FETCH_SETUP,
        FETCH_ACCESS,
        EXECUTE,
        MEM_SETUP,
        MEM_ACCESS,
        WRITEBACK
    } phaseT;

endpackage

// ==== logic/cycleControl.sv ====
`timescale 1ns/1ps

module cycleControl import rvPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  wordT  prdata,
    input  logic  pready,
    input  wordT  pc,
    input  wordT  aluResult,
    input  wordT  rs2Data,
    input  logic  memRead,
    input  logic  memWrite,
    input  wbSelT wbSel,
    output logic  psel,
    output logic  penable,
    output logic  pwrite,
    output wordT  paddr,
    output wordT  pwdata,
    output wordT  instr,
    output wordT  loadData,
    output logic  regWrite,
    output logic  pcAdvance
);

    phaseT phase;
    logic  memPhase;
    logic  xferDone;

    assign memPhase = (phase == MEM_SETUP) || (phase == MEM_ACCESS);
    assign xferDone = psel && penable && pready;   // APB completion edge

    // Word aligned data address, fetch address otherwise
    assign paddr  = memPhase ? {aluResult[XLEN-1:2], 2'b00} : pc;
    assign pwdata = rs2Data;

    assign pcAdvance = (phase == WRITEBACK);
    assign regWrite  = pcAdvance && (wbSel != WB_NONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase   <= FETCH_SETUP;
            psel    <= 1'b0;
            penable <= 1'b0;
            pwrite  <= 1'b0;
        end else begin
            case (phase)
                FETCH_SETUP: begin
                    if (psel) begin
                        phase   <= FETCH_ACCESS;
                        penable <= 1'b1;
                    end else begin
                        psel <= 1'b1;   // Bus still idle right after reset
                    end
                end
                FETCH_ACCESS: begin
                    if (pready) begin
                        phase   <= EXECUTE;
                        psel    <= 1'b0;
                        penable <= 1'b0;
                    end
                end
                EXECUTE: begin
                    if (memRead || memWrite) begin
                        phase  <= MEM_SETUP;
                        psel   <= 1'b1;
                        pwrite <= memWrite;
                    end else begin
                        phase <= WRITEBACK;
                    end
                end
                MEM_SETUP: begin
                    phase   <= MEM_ACCESS;
                    penable <= 1'b1;
                end
                MEM_ACCESS: begin
                    if (pready) begin
                        phase   <= WRITEBACK;
                        psel    <= 1'b0;
                        penable <= 1'b0;
                        pwrite  <= 1'b0;
                    end
                end
                WRITEBACK: begin
                    phase <= FETCH_SETUP;
                    psel  <= 1'b1;   // Next fetch starts at once
                end
                default: begin
                    phase   <= FETCH_SETUP;
                    psel    <= 1'b0;
                    penable <= 1'b0;
                    pwrite  <= 1'b0;
                end
            endcase
        end
    end

    // Captured on the completing edge of each transfer
    always_ff @(posedge clk) begin
        if (xferDone && !memPhase) begin
            instr <= prdata;
        end
        if (xferDone && memPhase) begin
            loadData <= prdata;
        end
    end

endmodule

// ==== logic/programCounter.sv ====
`timescale 1ns/1ps

module programCounter import rvPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   pcAdvance,
    input  pcModeT pcMode,
    input  wordT   imm,
    input  wordT   aluResult,
    input  logic   branchTaken,
    output wordT   pc
);

    wordT seqPc;
    wordT relPc;
    wordT nextPc;

    assign seqPc = pc + 32'd4;
    assign relPc = pc + imm;

    always_comb begin
        case (pcMode)
            PC_RELATIVE: nextPc = relPc;
            PC_ABSOLUTE: nextPc = aluResult;   // JALR target
            PC_BRANCH:   nextPc = branchTaken ? relPc : seqPc;
            default:     nextPc = seqPc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VECTOR;
        end else if (pcAdvance) begin
            pc <= {nextPc[XLEN-1:2], 2'b00};   // Misaligned targets are aligned
        end
    end

endmodule

// ==== logic/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder import rvPkg::*; (
    input  wordT     instr,
    output regAddrT  rs1,
    output regAddrT  rs2,
    output regAddrT  rd,
    output wordT     imm,
    output aluOpT    aluOp,
    output branchOpT branchOp,
    output opASelT   opASel,
    output logic     useImm,
    output pcModeT   pcMode,
    output wbSelT    wbSel,
    output logic     memRead,
    output logic     memWrite
);

    opcodeT     opcode;
    logic [2:0] funct3;
    logic       altOp;
    wordT       immI;
    wordT       immS;
    wordT       immB;
    wordT       immU;
    wordT       immJ;
    aluOpT      fieldOp;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign altOp  = instr[30];   // SUB and SRA select
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign branchOp = branchOpT'(funct3);

    // Operation from funct3, shared by register and immediate forms
    always_comb begin
        case (funct3)
            3'b000:  fieldOp = (opcode == OP_REG && altOp) ? ALU_SUB : ALU_ADD;
            3'b001:  fieldOp = ALU_SLL;
            3'b010:  fieldOp = ALU_SLT;
            3'b011:  fieldOp = ALU_SLTU;
            3'b100:  fieldOp = ALU_XOR;
            3'b101:  fieldOp = altOp ? ALU_SRA : ALU_SRL;
            3'b110:  fieldOp = ALU_OR;
            default: fieldOp = ALU_AND;
        endcase
    end

    always_comb begin
        imm      = immI;
        aluOp    = ALU_ADD;
        opASel   = OPA_RS1;
        useImm   = 1'b1;
        pcMode   = PC_SEQUENTIAL;
        wbSel    = WB_NONE;
        memRead  = 1'b0;
        memWrite = 1'b0;
        case (opcode)
            OP_REG: begin
                aluOp  = fieldOp;
                useImm = 1'b0;
                wbSel  = WB_ALU;
            end
            OP_IMM: begin
                aluOp = fieldOp;
                wbSel = WB_ALU;
            end
            OP_LUI: begin
                imm    = immU;
                opASel = OPA_ZERO;
                wbSel  = WB_ALU;
            end
            OP_AUIPC: begin
                imm    = immU;
                opASel = OPA_PC;
                wbSel  = WB_ALU;
            end
            OP_JAL: begin
                imm    = immJ;
                opASel = OPA_PC;
                pcMode = PC_RELATIVE;
                wbSel  = WB_LINK;
            end
            OP_JALR: begin
                pcMode = PC_ABSOLUTE;
                wbSel  = WB_LINK;
            end
            OP_BRANCH: begin
                imm    = immB;
                useImm = 1'b0;
                pcMode = PC_BRANCH;
            end
            OP_LOAD: begin
                wbSel   = WB_LOAD;
                memRead = 1'b1;
            end
            OP_STORE: begin
                imm      = immS;
                memWrite = 1'b1;
            end
            default: ;   // Executes as a no-op
        endcase
    end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps

module regFile import rvPkg::*; (
    input  logic    clk,
    input  logic    regWrite,
    input  regAddrT rd,
    input  regAddrT rs1,
    input  regAddrT rs2,
    input  wbSelT   wbSel,
    input  wordT    aluResult,
    input  wordT    loadData,
    input  wordT    pc,
    output wordT    rs1Data,
    output wordT    rs2Data
);

    wordT regs [1:REG_COUNT-1];   // No storage for x0
    wordT writeData;

    always_comb begin
        case (wbSel)
            WB_LINK: writeData = pc + 32'd4;
            WB_LOAD: writeData = loadData;
            default: writeData = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (regWrite && rd != '0) begin
            regs[rd] <= writeData;
        end
    end

    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu import rvPkg::*; (
    input  aluOpT    aluOp,
    input  branchOpT branchOp,
    input  opASelT   opASel,
    input  logic     useImm,
    input  wordT     rs1Data,
    input  wordT     rs2Data,
    input  wordT     pc,
    input  wordT     imm,
    output wordT     aluResult,
    output logic     branchTaken
);

    wordT       opA;
    wordT       opB;
    logic [4:0] shamt;

    always_comb begin
        case (opASel)
            OPA_PC:   opA = pc;
            OPA_ZERO: opA = '0;   // LUI
            default:  opA = rs1Data;
        endcase
    end

    assign opB   = useImm ? imm : rs2Data;
    assign shamt = opB[4:0];

    always_comb begin
        case (aluOp)
            ALU_SUB:  aluResult = opA - opB;
            ALU_SLL:  aluResult = opA << shamt;
            ALU_SRL:  aluResult = opA >> shamt;
            ALU_SRA:  aluResult = wordT'($signed(opA) >>> shamt);
            ALU_SLT:  aluResult = {31'b0, $signed(opA) < $signed(opB)};
            ALU_SLTU: aluResult = {31'b0, opA < opB};
            ALU_AND:  aluResult = opA & opB;
            ALU_OR:   aluResult = opA | opB;
            ALU_XOR:  aluResult = opA ^ opB;
            default:  aluResult = opA + opB;
        endcase
    end

    // Branch condition on the register operands
    always_comb begin
        case (branchOp)
            BR_BEQ:  branchTaken = (rs1Data == rs2Data);
            BR_BNE:  branchTaken = (rs1Data != rs2Data);
            BR_BLT:  branchTaken = $signed(rs1Data) < $signed(rs2Data);
            BR_BGE:  branchTaken = $signed(rs1Data) >= $signed(rs2Data);
            BR_BLTU: branchTaken = rs1Data < rs2Data;
            BR_BGEU: branchTaken = rs1Data >= rs2Data;
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

// ==== logic/rvMultiCycle.sv ====
`timescale 1ns/1ps

module rvMultiCycle import rvPkg::*; (
    input  logic clk,
    input  logic rst,
    input  wordT prdata,
    input  logic pready,
    output logic psel,
    output logic penable,
    output logic pwrite,
    output wordT paddr,
    output wordT pwdata
);

    wordT     instr;
    wordT     loadData;
    wordT     pc;
    wordT     imm;
    wordT     rs1Data;
    wordT     rs2Data;
    wordT     aluResult;
    regAddrT  rs1;
    regAddrT  rs2;
    regAddrT  rd;
    aluOpT    aluOp;
    branchOpT branchOp;
    opASelT   opASel;
    pcModeT   pcMode;
    wbSelT    wbSel;
    logic     useImm;
    logic     memRead;
    logic     memWrite;
    logic     regWrite;
    logic     pcAdvance;
    logic     branchTaken;

    cycleControl i_cycleControl (
        .clk       (clk),
        .rst       (rst),
        .prdata    (prdata),
        .pready    (pready),
        .pc        (pc),
        .aluResult (aluResult),
        .rs2Data   (rs2Data),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .wbSel     (wbSel),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .instr     (instr),
        .loadData  (loadData),
        .regWrite  (regWrite),
        .pcAdvance (pcAdvance)
    );

    programCounter i_programCounter (
        .clk         (clk),
        .rst         (rst),
        .pcAdvance   (pcAdvance),
        .pcMode      (pcMode),
        .imm         (imm),
        .aluResult   (aluResult),
        .branchTaken (branchTaken),
        .pc          (pc)
    );

    instrDecoder i_instrDecoder (
        .instr    (instr),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .imm      (imm),
        .aluOp    (aluOp),
        .branchOp (branchOp),
        .opASel   (opASel),
        .useImm   (useImm),
        .pcMode   (pcMode),
        .wbSel    (wbSel),
        .memRead  (memRead),
        .memWrite (memWrite)
    );

    regFile i_regFile (
        .clk       (clk),
        .regWrite  (regWrite),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .wbSel     (wbSel),
        .aluResult (aluResult),
        .loadData  (loadData),
        .pc        (pc),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data)
    );

    alu i_alu (
        .aluOp       (aluOp),
        .branchOp    (branchOp),
        .opASel      (opASel),
        .useImm      (useImm),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .pc          (pc),
        .imm         (imm),
        .aluResult   (aluResult),
        .branchTaken (branchTaken)
    );

endmodule

// ==== verif/rvMultiCycle_sva.sv ====
`timescale 1ns/1ps

module rvMultiCycleSva import rvPkg::*; (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic pready,
    input wordT paddr,
    input wordT pwdata
);

    int failCount = 0;   // Read by the testbench

    setupBeforeAccess: assert property (
        @(posedge clk) disable iff (rst) $rose(penable) |-> $past(psel) && psel
    ) else begin
        $error("APB access phase without a preceding setup phase");
        failCount++;
    end

    // Transfer held while the completer stalls
    stableWhileWaiting: assert property (
        @(posedge clk) disable iff (rst)
        psel && penable && !pready |=>
            psel && penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata)
    ) else begin
        $error("APB transfer signals changed during a wait state");
        failCount++;
    end

    writeOnlySelected: assert property (
        @(posedge clk) disable iff (rst) pwrite |-> psel
    ) else begin
        $error("pwrite high without psel");
        failCount++;
    end

endmodule

bind rvMultiCycle rvMultiCycleSva i_rvMultiCycleSva (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pready  (pready),
    .paddr   (paddr),
    .pwdata  (pwdata)
);

// ==== verif/tbRvMultiCycle.sv ====
`timescale 1ns/1ps

module tbRvMultiCycle import rvPkg::*; ();

    localparam int   INSTR_COUNT = 2000;
    localparam int   WAIT_LIMIT  = 16;   // Cycles allowed for any single wait
    localparam wordT LFSR_SEED   = 32'd17;

    logic clk = 1'b0;
    logic rst;
    wordT prdata;
    logic pready;
    logic psel;
    logic penable;
    logic pwrite;
    wordT paddr;
    wordT pwdata;

    wordT    lfsr = LFSR_SEED;
    wordT    xr [REG_COUNT];   // Reference register file
    wordT    pcModel;
    regAddrT prevRd;           // Last register that got a computed value

    // Fields of the instruction being served
    opcodeT     iOp;
    regAddrT    iRd;
    regAddrT    iRs1;
    regAddrT    iRs2;
    logic [2:0] iF3;
    logic       iAlt;
    wordT       iImm;

    rvMultiCycle i_rvMultiCycle (
        .clk     (clk),
        .rst     (rst),
        .prdata  (prdata),
        .pready  (pready),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata)
    );

    always #50 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1, one step per bit
    function automatic wordT randBits(input int n);
        wordT val;
        logic fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic wordT aluModel(input logic [2:0] f3, input logic alt,
                                      input wordT a, input wordT b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchModel(input logic [2:0] f3, input wordT a, input wordT b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic writeReg(input regAddrT rd, input wordT val);
        if (rd != '0) begin   // x0 keeps zero
            xr[rd] = val;
        end
    endtask

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            stopOnError($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stopOnError($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic waitSetup(input string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!(psel && !penable) && cycles < WAIT_LIMIT);
        if (!(psel && !penable)) begin
            stopOnError({"timeout waiting for the APB setup phase of a ", what});
        end
    endtask

    // Completer side, random wait states of 0 to 3 cycles
    task automatic serveTransfer(input wordT addr, input wordT rdata);
        int waits;
        int cycles;
        waits  = int'(randBits(2));
        prdata = rdata;
        pready = 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles == 1) begin
                checkBit("penable", penable, 1'b1);   // Access right after the setup cycle
            end
            if (penable) begin
                checkBit("psel", psel, 1'b1);
                checkWord("paddr", paddr, addr);
                pready = (waits == 0);
                if (waits > 0) begin
                    waits--;
                end
            end
        end while (penable && cycles < WAIT_LIMIT);
        if (penable) begin
            stopOnError("timeout waiting for an APB transfer to complete");
        end
        if (!pready) begin
            stopOnError("APB transfer completed while pready was low");
        end
        checkBit("psel", psel, 1'b0);   // Bus idle after completion
        pready = 1'b0;
    endtask

    task automatic busTransfer(input string what, input wordT addr, input logic write,
                               input wordT wdata, input wordT rdata);
        waitSetup(what);
        checkWord("paddr", paddr, addr);
        checkBit("pwrite", pwrite, write);
        if (write) begin
            checkWord("pwdata", pwdata, wdata);
        end
        serveTransfer(addr, rdata);
    endtask

    task automatic genInstr(input int n, output wordT word);
        logic [3:0] sel;
        wordT       r;
        sel  = 4'(randBits(4));
        iRd  = regAddrT'(randBits(5));
        iRs1 = regAddrT'(randBits(5));
        iRs2 = regAddrT'(randBits(5));
        iF3  = 3'(randBits(3));
        iAlt = 1'b0;
        r    = randBits(20);
        iImm = {{20{r[11]}}, r[11:0]};
        if (n < REG_COUNT - 1) begin
            // ADDI from x0 or LUI, so every register holds a known value
            iRd  = regAddrT'(n + 1);
            iRs1 = '0;
            iF3  = 3'd0;
            sel  = n[0] ? 4'd6 : 4'd3;
        end else if (prevRd != '0 && randBits(1) == 32'd1) begin
            sel  = (randBits(1) == 32'd1) ? 4'd15 : 4'd9;   // SW or JALR on the new value
            iRs1 = prevRd;
            iRs2 = prevRd;
        end
        case (sel)
            4'd0, 4'd1, 4'd2: begin
                iOp  = OP_REG;
                iAlt = (iF3 == 3'd0 || iF3 == 3'd5) && r[19];
                word = {1'b0, iAlt, 5'b0, iRs2, iRs1, iF3, iRd, OP_REG};
            end
            4'd3, 4'd4, 4'd5: begin
                iOp = OP_IMM;
                if (iF3 == 3'd1 || iF3 == 3'd5) begin
                    iAlt = (iF3 == 3'd5) && r[19];
                    iImm = {21'b0, iAlt, 5'b0, r[4:0]};
                end
                word = {iImm[11:0], iRs1, iF3, iRd, OP_IMM};
            end
            4'd6, 4'd7: begin
                iOp  = (sel == 4'd6) ? OP_LUI : OP_AUIPC;
                iImm = {r[19:0], 12'b0};
                word = {iImm[31:12], iRd, iOp};
            end
            4'd8: begin
                iOp  = OP_JAL;
                iImm = {{11{r[19]}}, r[19:0], 1'b0};
                word = {iImm[20], iImm[10:1], iImm[11], iImm[19:12], iRd, OP_JAL};
            end
            4'd9: begin
                iOp  = OP_JALR;
                word = {iImm[11:0], iRs1, 3'b000, iRd, OP_JALR};
            end
            4'd10, 4'd11: begin
                iOp = OP_BRANCH;
                if (iF3 == 3'd2 || iF3 == 3'd3) begin
                    iF3 = iF3 ^ 3'b110;
                end
                if (r[18]) begin
                    iRs2 = iRs1;   // Equal operands, so BEQ and BGE get taken
                end
                iImm = {{19{r[11]}}, r[11:0], 1'b0};
                word = {iImm[12], iImm[10:5], iRs2, iRs1, iF3, iImm[4:1], iImm[11], OP_BRANCH};
            end
            4'd12: begin
                iOp  = OP_LOAD;
                word = {iImm[11:0], iRs1, 3'b010, iRd, OP_LOAD};
            end
            default: begin
                iOp  = OP_STORE;
                word = {iImm[11:5], iRs2, iRs1, 3'b010, iImm[4:0], OP_STORE};
            end
        endcase
    endtask

    initial begin
        wordT word;
        wordT target;
        wordT addr;
        wordT data;
        rst     = 1'b1;
        prdata  = '0;
        pready  = 1'b0;
        pcModel = RESET_VECTOR;
        prevRd  = '0;
        for (int r = 0; r < REG_COUNT; r++) begin
            xr[r] = '0;
        end
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            checkBit("psel", psel, 1'b0);
        end
        rst = 1'b0;

        for (int n = 0; n < INSTR_COUNT; n++) begin
            genInstr(n, word);
            busTransfer("fetch", pcModel, 1'b0, '0, word);
            target = pcModel + 32'd4;
            addr   = xr[iRs1] + iImm;
            addr   = {addr[XLEN-1:2], 2'b00};
            prevRd = '0;
            case (iOp)
                OP_REG: begin
                    writeReg(iRd, aluModel(iF3, iAlt, xr[iRs1], xr[iRs2]));
                    prevRd = iRd;
                end
                OP_IMM: begin
                    writeReg(iRd, aluModel(iF3, iAlt, xr[iRs1], iImm));
                    prevRd = iRd;
                end
                OP_LUI: begin
                    writeReg(iRd, iImm);
                    prevRd = iRd;
                end
                OP_AUIPC: begin
                    writeReg(iRd, pcModel + iImm);
                    prevRd = iRd;
                end
                OP_JAL: begin
                    writeReg(iRd, pcModel + 32'd4);
                    target = pcModel + iImm;
                end
                OP_JALR: begin
                    target = xr[iRs1] + iImm;   // Taken before the link write, rd may be rs1
                    writeReg(iRd, pcModel + 32'd4);
                end
                OP_BRANCH: begin
                    if (branchModel(iF3, xr[iRs1], xr[iRs2])) begin
                        target = pcModel + iImm;
                    end
                end
                OP_LOAD: begin
                    data = randBits(32);
                    busTransfer("load", addr, 1'b0, '0, data);
                    writeReg(iRd, data);
                    prevRd = iRd;
                end
                OP_STORE: begin
                    busTransfer("store", addr, 1'b1, xr[iRs2], randBits(32));
                end
                default: ;
            endcase
            pcModel = {target[XLEN-1:2], 2'b00};
            if (i_rvMultiCycle.i_rvMultiCycleSva.failCount != 0) begin
                stopOnError("an APB protocol assertion failed");
            end
        end

        if (i_rvMultiCycle.i_rvMultiCycleSva.failCount != 0) begin
            $display("FAIL: see errors above");
            $fatal(1, "APB protocol assertions failed");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// ==== rvMultiCycle.f ====
logic/rvPkg.sv
logic/cycleControl.sv
logic/programCounter.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/alu.sv
logic/rvMultiCycle.sv
verif/rvMultiCycle_sva.sv
verif/tbRvMultiCycle.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbRvMultiCycle
RTL_TOP   ?= rvMultiCycle
FILELIST  ?= rvMultiCycle.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+10

RTL_FILES ?= $(filter logic/%,$(shell cat $(FILELIST)))
ALL_FILES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(ALL_FILES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
